// ==== fm_config_regs.sv ====
`timescale 1ns/1ns

module fm_config_regs (
    input  logic                                    i_Clock,
    input  logic                                    i_arst_n,
    input  logic                                    i_psel,
    input  logic                                    i_penable,
    input  logic                                    i_pwrite,
    input  logic [synth_config_pkg::APB_ADDR_W-1:0] i_paddr,
    input  logic [synth_config_pkg::APB_DATA_W-1:0] i_pwdata,
    output logic [synth_config_pkg::APB_DATA_W-1:0] o_prdata,
    output logic                                    o_pready,
    output logic                                    o_pslverr,
    output synth_config_pkg::cfg_write_t            o_cfg_write
);

    logic                         w_access;
    logic                         w_accept;
    logic                         w_mapped;
    logic [synth_config_pkg::APB_ADDR_W-1:0] w_page;
    synth_config_pkg::cfg_write_t w_decoded;

    // No wait states, every access phase completes
    assign w_access = i_psel & i_penable;
    assign o_pready = w_access;
    assign w_accept = w_access & o_pready & i_pwrite;

    // Registers are write-only
    assign o_prdata = '0;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------

    assign w_page = i_paddr & synth_config_pkg::ADDR_PAGE_MASK;

    always_comb begin
        w_decoded                = '0;
        w_decoded.voice_operator =
            i_paddr[synth_config_pkg::ADDR_WORD_LSB +: synth_types_pkg::OP_ID_W];
        w_decoded.data           = i_pwdata[synth_config_pkg::CFG_DATA_W-1:0];
        w_mapped                 = 1'b0;
        // Word aligned accesses only
        if (i_paddr[synth_config_pkg::ADDR_WORD_LSB-1:0] == '0) begin
            if (i_paddr == synth_config_pkg::ADDR_NOTE_ON) begin
                // Single register, the operator field is unused
                w_decoded.op             = synth_config_pkg::CFG_NOTE_ON;
                w_decoded.voice_operator = '0;
                w_mapped                 = 1'b1;
            end else if (w_page == synth_config_pkg::ADDR_PHASE_STEP_BASE) begin
                w_decoded.op = synth_config_pkg::CFG_PHASE_STEP;
                w_mapped     = 1'b1;
            end else if (w_page == synth_config_pkg::ADDR_WAVEFORM_BASE) begin
                w_decoded.op = synth_config_pkg::CFG_WAVEFORM;
                w_mapped     = 1'b1;
            end
        end
    end

    // Error only for writes that hit no register
    assign o_pslverr = w_access & i_pwrite & ~w_mapped;

    // ------------------------------------------------------------------------
    // Write pulse, one clock after the accepted access
    // ------------------------------------------------------------------------

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_cfg_write <= '0;
        end else if (w_accept && w_mapped) begin
            o_cfg_write <= w_decoded;
        end else begin
            // All-zero struct carries CFG_NONE
            o_cfg_write <= '0;
        end
    end

endmodule

// ==== fm_synth_core.f ====
synth_types_pkg.sv
synth_config_pkg.sv
fm_config_regs.sv
operator_sequencer.sv
stage_phase_accumulator.sv
stage_waveform.sv
fm_synth_core.sv
fm_synth_core_properties.sv
fm_synth_core_tb.sv

// ==== fm_synth_core.sv ====
`timescale 1ns/1ns

module fm_synth_core (
    input  logic                                    i_Clock,
    input  logic                                    i_arst_n,
    input  logic                                    i_psel,
    input  logic                                    i_penable,
    input  logic                                    i_pwrite,
    input  logic [synth_config_pkg::APB_ADDR_W-1:0] i_paddr,
    input  logic [synth_config_pkg::APB_DATA_W-1:0] i_pwdata,
    output logic [synth_config_pkg::APB_DATA_W-1:0] o_prdata,
    output logic                                    o_pready,
    output logic                                    o_pslverr,
    output synth_types_pkg::phase_sample_t          o_phase,
    output synth_types_pkg::op_sample_t             o_sample
);

    synth_config_pkg::cfg_write_t        cfg_write;
    synth_types_pkg::voice_operator_id_t seq_voice_operator;
    logic                                seq_valid;

    // ------------------------------------------------------------------------
    // Configuration and issue
    // ------------------------------------------------------------------------

    fm_config_regs config_regs_i (
        .i_Clock     (i_Clock),
        .i_arst_n    (i_arst_n),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .o_cfg_write (cfg_write)
    );

    operator_sequencer sequencer_i (
        .i_Clock          (i_Clock),
        .i_arst_n         (i_arst_n),
        .o_voice_operator (seq_voice_operator),
        .o_valid          (seq_valid)
    );

    // ------------------------------------------------------------------------
    // Operator pipeline, three clocks from issue to sample
    // ------------------------------------------------------------------------

    stage_phase_accumulator phase_accumulator_i (
        .i_Clock          (i_Clock),
        .i_arst_n         (i_arst_n),
        .i_voice_operator (seq_voice_operator),
        .i_valid          (seq_valid),
        .i_cfg_write      (cfg_write),
        .o_phase          (o_phase)
    );

    stage_waveform waveform_i (
        .i_Clock     (i_Clock),
        .i_arst_n    (i_arst_n),
        .i_phase     (o_phase),
        .i_cfg_write (cfg_write),
        .o_sample    (o_sample)
    );

endmodule

// ==== fm_synth_core_golden.txt ====
# W apb_addr data expected_pslverr (all hex)
# C operator visit (decimal, 0 is a note-off visit) expected_phase expected_sample (hex)
W 00 00001000 0
W 04 00003000 0
W 08 00004000 0
W 0C 00005000 0
W 44 00000001 0
W 48 00000002 0
W 4C 00000003 0
W 20 00000003 0
C 0 1 1000 9000
C 0 2 2000 a000
C 1 1 3000 7fff
C 2 1 4000 7fff
C 2 2 8000 ffff
C 2 3 c000 8000
C 2 4 0000 0000
C 3 2 a000 0000
C 3 4 4000 0000
C 1 3 9000 8000
C 1 6 2000 7fff
C 0 9 9000 1000
W 30 00000001 1
C 0 12 c000 4000
C 1 8 8000 8000
W 20 00000002 0
C 0 0 0000 0000
C 1 0 0000 0000
W 20 00000003 0
C 0 1 1000 9000
C 1 2 6000 7fff

// ==== fm_synth_core_properties.sv ====
`timescale 1ns/1ns

module fm_synth_core_properties (
    input logic                           i_Clock,
    input logic                           i_arst_n,
    input logic                           i_psel,
    input logic                           i_penable,
    input logic                           i_pready,
    input synth_types_pkg::phase_sample_t i_phase,
    input synth_types_pkg::op_sample_t    i_sample
);

    // ------------------------------------------------------------------------
    // APB and reset
    // ------------------------------------------------------------------------

    // No wait states
    pready_in_access: assert property (@(posedge i_Clock)
        (i_psel && i_penable) |-> i_pready)
        else $error("pready low in an access phase");

    sample_idle_in_reset: assert property (@(posedge i_Clock)
        !i_arst_n |-> !i_sample.valid)
        else $error("sample valid during reset");

    // ------------------------------------------------------------------------
    // Pipeline order
    // ------------------------------------------------------------------------

    // 3-bit ID wraps from 7 to 0
    phase_id_steps: assert property (@(posedge i_Clock) disable iff (!i_arst_n)
        (i_phase.valid && $past(i_phase.valid)) |->
        (i_phase.voice_operator ==
            synth_types_pkg::voice_operator_id_t'($past(i_phase.voice_operator) + 1'b1)))
        else $error("phase IDs out of order");

    sample_follows_phase: assert property (@(posedge i_Clock) disable iff (!i_arst_n)
        i_phase.valid |=> i_sample.valid)
        else $error("sample valid missing after phase valid");

    sample_not_early: assert property (@(posedge i_Clock) disable iff (!i_arst_n)
        !i_phase.valid |=> !i_sample.valid)
        else $error("sample valid without phase valid");

endmodule

// ==== fm_synth_core_tb.sv ====
`timescale 1ns/1ns

module fm_synth_core_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 400;
    localparam int IDLE_SAMPLES = 16;
    localparam int MAX_VISIT    = 32;
    localparam int NUM_OPS      = synth_types_pkg::NUM_VOICE_OPERATORS;

    logic        i_Clock;
    logic        i_arst_n;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [7:0]  i_paddr;
    logic [31:0] i_pwdata;
    logic [31:0] o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    synth_types_pkg::phase_sample_t o_phase;
    synth_types_pkg::op_sample_t    o_sample;

    // Per-operator visit records, index 0 holds the latest note-off visit
    synth_types_pkg::phase_sample_t rec_phase  [NUM_OPS][MAX_VISIT];
    synth_types_pkg::op_sample_t    rec_sample [NUM_OPS][MAX_VISIT];
    int   on_count        [NUM_OPS] = '{default: 0};
    int   off_sample_seen [NUM_OPS] = '{default: 0};
    logic sample_done     [NUM_OPS] = '{default: 1'b0};

    // Visit waiting for its sample one clock later
    logic pend_valid = 1'b0;
    int   pend_op;
    int   pend_k;
    logic have_prev = 1'b0;
    synth_types_pkg::voice_operator_id_t prev_id;
    int   mon_op;

    fm_synth_core dut_i (
        .i_Clock   (i_Clock),
        .i_arst_n  (i_arst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_phase   (o_phase),
        .o_sample  (o_sample)
    );

    bind fm_synth_core fm_synth_core_properties properties_i (
        .i_Clock   (i_Clock),
        .i_arst_n  (i_arst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pready  (o_pready),
        .i_phase   (o_phase),
        .i_sample  (o_sample)
    );

    initial begin
        i_Clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_Clock = ~i_Clock;
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic check_phase(input string name, input synth_types_pkg::phase_sample_t got,
                               input synth_types_pkg::phase_sample_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
            $display("TESTBENCH FAILED");
            $fatal(1, "phase mismatch");
        end
    endtask

    task automatic check_sample(input string name, input synth_types_pkg::op_sample_t got,
                                input synth_types_pkg::op_sample_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
            $display("TESTBENCH FAILED");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_op_id(input string name, input synth_types_pkg::voice_operator_id_t got,
                               input synth_types_pkg::voice_operator_id_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, exp, got);
            $display("TESTBENCH FAILED");
            $fatal(1, "operator order mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, got);
            $display("TESTBENCH FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_rdata(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
            $display("TESTBENCH FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    endtask

    // ------------------------------------------------------------------------
    // Monitor, records visits and checks operator order
    // ------------------------------------------------------------------------

    always @(posedge i_Clock) begin
        if (pend_valid) begin
            rec_sample[pend_op][pend_k] = o_sample;
            if (pend_k == 0) begin
                off_sample_seen[pend_op] = off_sample_seen[pend_op] + 1;
            end else begin
                sample_done[pend_op] = 1'b1;
            end
        end
        pend_valid = 1'b0;
        if (o_phase.valid) begin
            mon_op = int'(o_phase.voice_operator);
            // Note-off restarts the count, the next note-on visit is visit 1
            if (o_phase.note_on) begin
                if (on_count[mon_op] < MAX_VISIT - 1) begin
                    on_count[mon_op] = on_count[mon_op] + 1;
                end
            end else begin
                on_count[mon_op] = 0;
            end
            rec_phase[mon_op][on_count[mon_op]] = o_phase;
            sample_done[mon_op] = 1'b0;
            pend_valid = 1'b1;
            pend_op    = mon_op;
            pend_k     = on_count[mon_op];
        end
        if (o_sample.valid) begin
            if (have_prev) begin
                check_op_id("o_sample.voice_operator", o_sample.voice_operator,
                            synth_types_pkg::voice_operator_id_t'(prev_id + 1'b1));
            end
            have_prev = 1'b1;
            prev_id   = o_sample.voice_operator;
        end
    end

    // ------------------------------------------------------------------------
    // APB access and golden checks
    // ------------------------------------------------------------------------

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] data, output logic err,
                              output logic [31:0] rdata);
        int   cycles;
        logic done;
        @(posedge i_Clock);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= write;
        i_paddr   <= addr;
        i_pwdata  <= data;
        @(posedge i_Clock);
        i_penable <= 1'b1;
        cycles = 0;
        done   = 1'b0;
        err    = 1'b0;
        rdata  = '0;
        while (!done) begin
            @(posedge i_Clock);
            if (o_pready) begin
                done  = 1'b1;
                err   = o_pslverr;
                rdata = o_prdata;
            end else begin
                cycles++;
                if (cycles >= WAIT_LIMIT) begin
                    stop_on_timeout("pready");
                end
            end
        end
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
    endtask

    task automatic run_check(input int op, input int k, input logic [15:0] exp_phase,
                             input logic [15:0] exp_sample);
        int cycles;
        int start;
        synth_types_pkg::phase_sample_t p_exp;
        synth_types_pkg::op_sample_t    s_exp;
        cycles = 0;
        start  = off_sample_seen[op];
        forever begin
            @(negedge i_Clock);
            if (k == 0 && off_sample_seen[op] > start) break;
            if (k != 0 && (on_count[op] > k || (on_count[op] == k && sample_done[op]))) break;
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                stop_on_timeout($sformatf("visit %0d of operator %0d", k, op));
            end
        end
        p_exp.voice_operator = synth_types_pkg::voice_operator_id_t'(op);
        p_exp.phase          = exp_phase;
        p_exp.note_on        = (k != 0);
        p_exp.valid          = 1'b1;
        s_exp.voice_operator = synth_types_pkg::voice_operator_id_t'(op);
        s_exp.sample         = exp_sample;
        s_exp.valid          = 1'b1;
        check_phase("o_phase", rec_phase[op][k], p_exp);
        check_sample("o_sample", rec_sample[op][k], s_exp);
    endtask

    initial begin
        int          fd;
        int          status;
        int          cycles;
        int          idle_seen;
        int          checks_run;
        int          op_val;
        int          visit_val;
        byte         kind;
        string       line;
        logic [31:0] addr_val;
        logic [31:0] data_val;
        logic [31:0] err_val;
        logic [31:0] phase_val;
        logic [31:0] sample_val;
        logic [31:0] rdata;
        logic        err;
        synth_types_pkg::voice_operator_id_t phase_id;
        synth_types_pkg::voice_operator_id_t sample_id;

        i_arst_n  = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        checks_run = 0;
        repeat (RESET_CYCLES) @(posedge i_Clock);
        i_arst_n <= 1'b1;

        // Before any note-on every operator stays at zero, IDs start at 0
        idle_seen = 0;
        cycles    = 0;
        phase_id  = '0;
        sample_id = '0;
        while (idle_seen < IDLE_SAMPLES) begin
            @(negedge i_Clock);
            if (o_phase.valid) begin
                check_phase("o_phase", o_phase, '{phase_id, 16'h0, 1'b0, 1'b1});
                phase_id = phase_id + 1'b1;
            end
            if (o_sample.valid) begin
                check_sample("o_sample", o_sample, '{sample_id, 16'sh0, 1'b1});
                sample_id = sample_id + 1'b1;
                idle_seen++;
            end
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                stop_on_timeout("first valid samples");
            end
        end

        fd = $fopen("fm_synth_core_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file");
            $display("TESTBENCH FAILED");
            $fatal(1, "missing golden file");
        end
        while (!$feof(fd)) begin
            line   = "";
            status = $fgets(line, fd);
            if (status != 0 && line.len() > 1 && line.getc(0) != "#") begin
                kind = line.getc(0);
                if (kind == "W") begin
                    status = $sscanf(line, "%c %h %h %h", kind, addr_val, data_val, err_val);
                    if (status != 4) begin
                        $display("Malformed write line in golden file: %s", line);
                        $display("TESTBENCH FAILED");
                        $fatal(1, "bad golden line");
                    end
                    apb_access(1'b1, addr_val[7:0], data_val, err, rdata);
                    check_flag("o_pslverr", err, err_val[0]);
                end else if (kind == "C") begin
                    status = $sscanf(line, "%c %d %d %h %h", kind, op_val, visit_val,
                                     phase_val, sample_val);
                    if (status != 5) begin
                        $display("Malformed check line in golden file: %s", line);
                        $display("TESTBENCH FAILED");
                        $fatal(1, "bad golden line");
                    end
                    run_check(op_val, visit_val, phase_val[15:0], sample_val[15:0]);
                    checks_run++;
                end else begin
                    $display("Unknown line kind in golden file: %s", line);
                    $display("TESTBENCH FAILED");
                    $fatal(1, "bad golden line");
                end
            end
        end
        $fclose(fd);

        // Registers are write-only, a read of a written step returns zero
        apb_access(1'b0, 8'h04, 32'h0, err, rdata);
        check_rdata("o_prdata", rdata, 32'h0);
        check_flag("o_pslverr", err, 1'b0);

        if (checks_run > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("The golden file held no checks");
            $display("TESTBENCH FAILED");
            $fatal(1, "empty golden file");
        end
    end

endmodule

// ==== operator_sequencer.sv ====
`timescale 1ns/1ns

module operator_sequencer (
    input  logic                                i_Clock,
    input  logic                                i_arst_n,
    output synth_types_pkg::voice_operator_id_t o_voice_operator,
    output logic                                o_valid
);

    synth_types_pkg::voice_operator_id_t r_voice_operator;
    logic                                r_valid;
    logic                                w_last;

    // Last operator before wrapping to zero
    assign w_last = (r_voice_operator ==
        synth_types_pkg::voice_operator_id_t'(synth_types_pkg::NUM_VOICE_OPERATORS - 1));

    // ------------------------------------------------------------------------
    // Round-robin issue, one operator per clock
    // ------------------------------------------------------------------------

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_voice_operator <= '0;
            r_valid          <= 1'b0;
        end else begin
            // Valid rises on the first clock after reset release
            r_valid <= 1'b1;
            // ID 0 is held for the first valid clock, then steps
            if (r_valid) begin
                if (w_last) begin
                    r_voice_operator <= '0;
                end else begin
                    r_voice_operator <= r_voice_operator + 1'b1;
                end
            end
        end
    end

    assign o_voice_operator = r_voice_operator;
    assign o_valid          = r_valid;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fm_synth_core_tb \
    -f fm_synth_core.f -o fm_synth_core_sim \
    && ./obj_dir/fm_synth_core_sim > sim.log 2>&1
grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed, see sim.log"; exit 1; }

// ==== stage_phase_accumulator.sv ====
`timescale 1ns/1ns

module stage_phase_accumulator (
    input  logic                                i_Clock,
    input  logic                                i_arst_n,
    input  synth_types_pkg::voice_operator_id_t i_voice_operator,
    input  logic                                i_valid,
    input  synth_config_pkg::cfg_write_t        i_cfg_write,
    output synth_types_pkg::phase_sample_t      o_phase
);

    // Per-operator tables
    logic [synth_types_pkg::PHASE_W-1:0] r_accumulators [synth_types_pkg::NUM_VOICE_OPERATORS];
    logic [synth_types_pkg::PHASE_W-1:0] r_phase_steps  [synth_types_pkg::NUM_VOICE_OPERATORS];

    // One note-on bit per voice
    logic [synth_types_pkg::NUM_VOICES-1:0] r_note_on_map;

    // Clock 1 pipeline registers
    synth_types_pkg::voice_operator_id_t r_voice_operator;
    logic                                r_valid;
    logic                                r_note_on;
    logic [synth_types_pkg::PHASE_W-1:0] r_accum;
    logic [synth_types_pkg::PHASE_W-1:0] r_step;

    logic [synth_types_pkg::PHASE_W-1:0] w_stepped;

    // Wraps modulo 2^16, note-off forces the phase back to zero
    always_comb begin
        w_stepped = r_note_on ? (r_accum + r_step) : '0;
    end

    // ------------------------------------------------------------------------
    // Clock 1, table reads, configuration and write-back
    // ------------------------------------------------------------------------

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < synth_types_pkg::NUM_VOICE_OPERATORS; i++) begin
                r_accumulators[i] <= '0;
                r_phase_steps[i]  <= '0;
            end
            r_note_on_map    <= '0;
            r_voice_operator <= '0;
            r_valid          <= 1'b0;
            r_note_on        <= 1'b0;
            r_accum          <= '0;
            r_step           <= '0;
        end else begin
            if (i_cfg_write.op == synth_config_pkg::CFG_PHASE_STEP) begin
                r_phase_steps[i_cfg_write.voice_operator] <= i_cfg_write.data;
            end
            if (i_cfg_write.op == synth_config_pkg::CFG_NOTE_ON) begin
                r_note_on_map <= i_cfg_write.data[synth_types_pkg::NUM_VOICES-1:0];
            end

            // Feedback from clock 2, lands long before this operator returns
            if (r_valid) begin
                r_accumulators[r_voice_operator] <= w_stepped;
            end

            r_accum          <= r_accumulators[i_voice_operator];
            r_step           <= r_phase_steps[i_voice_operator];
            r_note_on        <= r_note_on_map[synth_types_pkg::get_voice_id(i_voice_operator)];
            r_voice_operator <= i_voice_operator;
            r_valid          <= i_valid;
        end
    end

    // ------------------------------------------------------------------------
    // Clock 2, output register
    // ------------------------------------------------------------------------

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_phase <= '0;
        end else begin
            o_phase.voice_operator <= r_voice_operator;
            o_phase.phase          <= w_stepped;
            o_phase.note_on        <= r_note_on;
            o_phase.valid          <= r_valid;
        end
    end

endmodule

// ==== stage_waveform.sv ====
`timescale 1ns/1ns

module stage_waveform (
    input  logic                           i_Clock,
    input  logic                           i_arst_n,
    input  synth_types_pkg::phase_sample_t i_phase,
    input  synth_config_pkg::cfg_write_t   i_cfg_write,
    output synth_types_pkg::op_sample_t    o_sample
);

    // Waveform per operator, reset to saw
    synth_types_pkg::waveform_t r_waveforms [synth_types_pkg::NUM_VOICE_OPERATORS];

    synth_types_pkg::waveform_t                   w_waveform;
    logic signed [synth_types_pkg::SAMPLE_W-1:0]  w_saw;
    logic signed [synth_types_pkg::SAMPLE_W-1:0]  w_doubled;
    logic signed [synth_types_pkg::SAMPLE_W-1:0]  w_sample;

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < synth_types_pkg::NUM_VOICE_OPERATORS; i++) begin
                r_waveforms[i] <= synth_types_pkg::WAVE_SAW;
            end
        end else if (i_cfg_write.op == synth_config_pkg::CFG_WAVEFORM) begin
            r_waveforms[i_cfg_write.voice_operator] <=
                synth_types_pkg::waveform_t'(i_cfg_write.data[1:0]);
        end
    end

    // ------------------------------------------------------------------------
    // Phase to sample
    // ------------------------------------------------------------------------

    always_comb begin
        w_waveform = r_waveforms[i_phase.voice_operator];
        // Offset binary to two's complement
        w_saw      = {~i_phase.phase[synth_types_pkg::PHASE_W-1],
                      i_phase.phase[synth_types_pkg::PHASE_W-2:0]};
        // Saw times two, top bit drops out
        w_doubled  = {i_phase.phase[synth_types_pkg::PHASE_W-2:0], 1'b0};
        w_sample   = '0;
        if (i_phase.note_on) begin
            case (w_waveform)
                synth_types_pkg::WAVE_SAW: w_sample = w_saw;
                synth_types_pkg::WAVE_SQUARE: begin
                    w_sample = i_phase.phase[synth_types_pkg::PHASE_W-1] ?
                        synth_types_pkg::SAMPLE_MIN : synth_types_pkg::SAMPLE_MAX;
                end
                synth_types_pkg::WAVE_TRIANGLE: begin
                    // Rising quarters keep the doubled saw, falling ones invert it
                    if (i_phase.phase[synth_types_pkg::PHASE_W-1] ==
                        i_phase.phase[synth_types_pkg::PHASE_W-2]) begin
                        w_sample = w_doubled;
                    end else begin
                        w_sample = ~w_doubled;
                    end
                end
                default: w_sample = '0;
            endcase
        end
    end

    always_ff @(posedge i_Clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_sample <= '0;
        end else begin
            o_sample.voice_operator <= i_phase.voice_operator;
            o_sample.sample         <= w_sample;
            o_sample.valid          <= i_phase.valid;
        end
    end

endmodule

// ==== synth_config_pkg.sv ====
package synth_config_pkg;

    // ------------------------------------------------------------------------
    // APB register map
    // ------------------------------------------------------------------------

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Byte addresses, one 32-bit word per operator
    localparam int ADDR_WORD_LSB = 2;

    localparam logic [APB_ADDR_W-1:0] ADDR_PHASE_STEP_BASE = 8'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_NOTE_ON         = 8'h20;
    localparam logic [APB_ADDR_W-1:0] ADDR_WAVEFORM_BASE   = 8'h40;

    // Clears the operator index and byte offset, leaving the table page
    localparam logic [APB_ADDR_W-1:0] ADDR_PAGE_MASK =
        ~APB_ADDR_W'((1 << (ADDR_WORD_LSB + synth_types_pkg::OP_ID_W)) - 1);

    // ------------------------------------------------------------------------
    // Configuration writes towards the stages
    // ------------------------------------------------------------------------

    localparam int CFG_DATA_W = 16;

    typedef enum logic [1:0] {
        CFG_NONE       = 2'd0,
        CFG_PHASE_STEP = 2'd1,
        CFG_NOTE_ON    = 2'd2,
        CFG_WAVEFORM   = 2'd3
    } cfg_op_t;

    // One-clock pulse, CFG_NONE when idle, 21 bits
    typedef struct packed {
        cfg_op_t                             op;
        synth_types_pkg::voice_operator_id_t voice_operator;
        logic [CFG_DATA_W-1:0]               data;
    } cfg_write_t;

endpackage

// ==== synth_types_pkg.sv ====
package synth_types_pkg;

    // ------------------------------------------------------------------------
    // Operator counts
    // ------------------------------------------------------------------------

    localparam int NUM_VOICES          = 4;
    localparam int OPS_PER_VOICE       = 2;
    localparam int NUM_VOICE_OPERATORS = NUM_VOICES * OPS_PER_VOICE;

    // Index widths follow from the counts
    localparam int OP_ID_W    = $clog2(NUM_VOICE_OPERATORS);
    localparam int VOICE_ID_W = $clog2(NUM_VOICES);

    // Phase is unsigned so that overflow gives the wanted frequency
    localparam int PHASE_W  = 16;
    localparam int SAMPLE_W = 16;

    // Full-scale sample levels
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 16'sh7FFF;
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 16'sh8000;

    // Upper bits select the voice, low bit the operator inside it
    typedef logic [OP_ID_W-1:0]    voice_operator_id_t;
    typedef logic [VOICE_ID_W-1:0] voice_id_t;

    typedef enum logic [1:0] {
        WAVE_SAW      = 2'd0,
        WAVE_SQUARE   = 2'd1,
        WAVE_TRIANGLE = 2'd2,
        WAVE_SILENT   = 2'd3
    } waveform_t;

    // ------------------------------------------------------------------------
    // Pipeline payloads
    // ------------------------------------------------------------------------

    // Phase accumulator output, 21 bits
    typedef struct packed {
        voice_operator_id_t  voice_operator;
        logic [PHASE_W-1:0]  phase;
        logic                note_on;
        logic                valid;
    } phase_sample_t;

    // Waveform stage output, 20 bits
    typedef struct packed {
        voice_operator_id_t         voice_operator;
        logic signed [SAMPLE_W-1:0] sample;
        logic                       valid;
    } op_sample_t;

    // Voice that owns an operator
    function automatic voice_id_t get_voice_id(input voice_operator_id_t op_id);
        return op_id[OP_ID_W-1 -: VOICE_ID_W];
    endfunction

endpackage
